/* source/debug_pkg.sv */
package debug_pkg;

    ////////////////////////////////////////////////////////////
    // uart timing and bus geometry
    ////////////////////////////////////////////////////////////

    // small divisor for simulation
    localparam logic [15:0] clks_per_baud = 16'd16;

    localparam int addr_width = 16;
    localparam int data_width = 16;

    // framing characters of the ascii protocol
    localparam logic [7:0] char_preamble = 8'h4D;
    localparam logic [7:0] char_cr       = 8'h0D;
    localparam logic [7:0] char_lf       = 8'h0A;

    localparam logic [addr_width-1:0] trig_base_addr = 16'h0000;
    localparam int trig_reg_count = 8;
    localparam int op_width = 4;

    ////////////////////////////////////////////////////////////
    // enums and bus structs
    ////////////////////////////////////////////////////////////

    typedef enum logic [op_width-1:0] {
        op_disable  = 4'd0,
        op_rising   = 4'd1,
        op_falling  = 4'd2,
        op_changing = 4'd3,
        op_gt       = 4'd4,
        op_lt       = 4'd5,
        op_geq      = 4'd6,
        op_leq      = 4'd7,
        op_eq       = 4'd8,
        op_neq      = 4'd9
    } trig_op_e;

    typedef enum logic {
        st_acquire = 1'b0,
        st_error   = 1'b1
    } parse_state_e;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic                  write;
        logic                  valid;
    } bus_req_t;

    typedef struct packed {
        logic [data_width-1:0] rdata;
        logic                  valid;
    } bus_rsp_t;

    typedef struct packed {
        logic       probe_a;
        logic       probe_b;
        logic       probe_c;
        logic [3:0] probe_d;
    } probe_t;

endpackage

/* source/uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] rx_byte_o,
    output logic       rx_valid_o
);

    logic [1:0]  sync_q;
    logic        rx_s;
    // 0 idle, 1 to 8 data bits, 9 stop bit
    logic [3:0]  bit_state;
    logic [15:0] baud_cnt;
    logic [15:0] strobe_cnt;

    assign rx_s = sync_q[1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_i};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bit_state  <= 4'd0;
            baud_cnt   <= 16'd0;
            strobe_cnt <= 16'd0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= (strobe_cnt == 16'd1);
            if (strobe_cnt != 16'd0) begin
                strobe_cnt <= strobe_cnt - 16'd1;
            end
            if (bit_state == 4'd0) begin
                // start edge, first sample lands in the middle of bit 0
                if (!rx_s) begin
                    bit_state <= 4'd1;
                    baud_cnt  <= debug_pkg::clks_per_baud + debug_pkg::clks_per_baud / 2
                                 - 16'd1;
                end
            end else if (baud_cnt != 16'd0) begin
                baud_cnt <= baud_cnt - 16'd1;
            end else if (bit_state == 4'd9) begin
                // back to idle at mid stop bit so the next start edge is not missed
                bit_state <= 4'd0;
                if (rx_s) begin
                    strobe_cnt <= debug_pkg::clks_per_baud / 2;
                end
            end else begin
                bit_state <= bit_state + 4'd1;
                baud_cnt  <= debug_pkg::clks_per_baud - 16'd1;
            end
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (bit_state inside {[4'd1:4'd8]} && baud_cnt == 16'd0) begin
            rx_byte_o <= {rx_s, rx_byte_o[7:1]};
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) rx_valid_o |=> !rx_valid_o);

endmodule

/* source/request_parser.sv */
`timescale 1ns/1ps

module request_parser (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [7:0]           rx_byte_i,
    input  logic                 rx_valid_i,
    output debug_pkg::bus_req_t  req_o
);

    debug_pkg::parse_state_e state;
    // 0 waits for the preamble, then 1 + number of hex digits taken
    logic [3:0] char_cnt;
    logic       is_hex;
    logic       is_eol;
    logic [3:0] nib;

    ////////////////////////////////////////////////////////////
    // character decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        is_hex = 1'b1;
        nib    = rx_byte_i[3:0];
        if (rx_byte_i >= "0" && rx_byte_i <= "9") begin
            nib = rx_byte_i[3:0];
        end else if (rx_byte_i >= "A" && rx_byte_i <= "F") begin
            // 'A' is 0x41
            nib = rx_byte_i[3:0] + 4'd9;
        end else begin
            is_hex = 1'b0;
        end
    end

    assign is_eol = (rx_byte_i == debug_pkg::char_cr) || (rx_byte_i == debug_pkg::char_lf);

    ////////////////////////////////////////////////////////////
    // line FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state       <= debug_pkg::st_acquire;
            char_cnt    <= 4'd0;
            req_o.valid <= 1'b0;
            req_o.write <= 1'b0;
        end else begin
            req_o.valid <= 1'b0;
            if (rx_valid_i) begin
                case (state)
                    debug_pkg::st_error: begin
                        // resync on the next line end
                        if (is_eol) begin
                            state    <= debug_pkg::st_acquire;
                            char_cnt <= 4'd0;
                        end
                    end
                    default: begin
                        if (char_cnt == 4'd0) begin
                            if (rx_byte_i == debug_pkg::char_preamble) begin
                                char_cnt <= 4'd1;
                            end
                        end else if (is_eol) begin
                            // 4 digits read, 8 digits write, any other count drops the line
                            char_cnt <= 4'd0;
                            if (char_cnt == 4'd5 || char_cnt == 4'd9) begin
                                req_o.valid <= 1'b1;
                                req_o.write <= (char_cnt == 4'd9);
                            end
                        end else if (is_hex && char_cnt != 4'd9) begin
                            char_cnt <= char_cnt + 4'd1;
                            if (char_cnt <= 4'd4) begin
                                req_o.addr <= {req_o.addr[debug_pkg::addr_width-5:0], nib};
                            end else begin
                                req_o.wdata <= {req_o.wdata[debug_pkg::data_width-5:0], nib};
                            end
                        end else begin
                            state <= debug_pkg::st_error;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* source/probe_trigger.sv */
`timescale 1ns/1ps

module probe_trigger #(
    parameter int probe_width = 1
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [probe_width-1:0] probe_i,
    input  debug_pkg::trig_op_e    op_i,
    input  logic [probe_width-1:0] arg_i,
    output logic                   hit_o
);

    logic [probe_width-1:0] prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            prev_q <= '0;
        end else begin
            prev_q <= probe_i;
        end
    end

    // edge ops look at the previous sample, the rest at the argument
    always_comb begin
        case (op_i)
            debug_pkg::op_rising:   hit_o = (probe_i > prev_q);
            debug_pkg::op_falling:  hit_o = (probe_i < prev_q);
            debug_pkg::op_changing: hit_o = (probe_i != prev_q);
            debug_pkg::op_gt:       hit_o = (probe_i > arg_i);
            debug_pkg::op_lt:       hit_o = (probe_i < arg_i);
            debug_pkg::op_geq:      hit_o = (probe_i >= arg_i);
            debug_pkg::op_leq:      hit_o = (probe_i <= arg_i);
            debug_pkg::op_eq:       hit_o = (probe_i == arg_i);
            debug_pkg::op_neq:      hit_o = (probe_i != arg_i);
            default:                hit_o = 1'b0;
        endcase
    end

endmodule

/* source/trigger_block.sv */
`timescale 1ns/1ps

module trigger_block (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  debug_pkg::bus_req_t  req_i,
    output debug_pkg::bus_rsp_t  rsp_o,
    input  debug_pkg::probe_t    probes_i,
    output logic                 trig_o
);

    logic [debug_pkg::op_width-1:0]   op_q [4];
    logic [3:0]                       arg_q [4];
    logic [3:0]                       probe_val [4];
    logic [3:0]                       hits;
    logic [debug_pkg::addr_width-1:0] offset;
    logic                             in_range;
    logic [1:0]                       probe_sel;
    logic [3:0]                       arg_mask;
    logic [debug_pkg::data_width-1:0] rd_word;

    ////////////////////////////////////////////////////////////
    // register decode, even address op, odd address arg
    ////////////////////////////////////////////////////////////

    assign offset    = req_i.addr - debug_pkg::trig_base_addr;
    assign in_range  = offset < debug_pkg::trig_reg_count;
    assign probe_sel = offset[2:1];
    // probe d is 4 bits wide, the others are single bits
    assign arg_mask  = (probe_sel == 2'd3) ? 4'hF : 4'h1;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 4; k++) begin
                op_q[k]  <= '0;
                arg_q[k] <= '0;
            end
        end else if (req_i.valid && req_i.write && in_range) begin
            if (offset[0]) begin
                arg_q[probe_sel] <= req_i.wdata[3:0] & arg_mask;
            end else begin
                op_q[probe_sel] <= req_i.wdata[debug_pkg::op_width-1:0];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (in_range) begin
            if (offset[0]) begin
                rd_word[3:0] = arg_q[probe_sel];
            end else begin
                rd_word[debug_pkg::op_width-1:0] = op_q[probe_sel];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= req_i.valid && !req_i.write;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid && !req_i.write) begin
            rsp_o.rdata <= rd_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // probe compare and trigger
    ////////////////////////////////////////////////////////////

    assign probe_val[0] = {3'b000, probes_i.probe_a};
    assign probe_val[1] = {3'b000, probes_i.probe_b};
    assign probe_val[2] = {3'b000, probes_i.probe_c};
    assign probe_val[3] = probes_i.probe_d;

    for (genvar k = 0; k < 4; k++) begin : g_probe
        localparam int pw = (k == 3) ? 4 : 1;

        probe_trigger #(
            .probe_width(pw)
        ) probe_trigger_inst (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .probe_i (probe_val[k][pw-1:0]),
            .op_i    (debug_pkg::trig_op_e'(op_q[k])),
            .arg_i   (arg_q[k][pw-1:0]),
            .hit_o   (hits[k])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= |hits;
        end
    end

    // one single cycle response per read request
    assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.valid |=> !rsp_o.valid);

endmodule

/* source/response_encoder.sv */
`timescale 1ns/1ps

module response_encoder (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  debug_pkg::bus_rsp_t  rsp_i,
    output logic [7:0]           tx_byte_o,
    output logic                 tx_valid_o,
    input  logic                 tx_ready_i
);

    logic                             busy;
    logic [2:0]                       char_idx;
    logic [debug_pkg::data_width-1:0] data_q;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        logic [7:0] v;
        v = {4'h0, n};
        // upper case digits
        return (n < 4'd10) ? (v + 8'h30) : (v + 8'h37);
    endfunction

    assign tx_valid_o = busy;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            char_idx <= 3'd0;
        end else if (!busy) begin
            if (rsp_i.valid) begin
                busy     <= 1'b1;
                char_idx <= 3'd0;
            end
        end else if (tx_ready_i) begin
            // LF accepted, reply done
            if (char_idx == 3'd6) begin
                busy <= 1'b0;
            end
            char_idx <= char_idx + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && rsp_i.valid) begin
            data_q <= rsp_i.rdata;
        end
    end

    // M, four digits msb first, CR, LF
    always_comb begin
        case (char_idx)
            3'd0:    tx_byte_o = debug_pkg::char_preamble;
            3'd1:    tx_byte_o = hex_char(data_q[15:12]);
            3'd2:    tx_byte_o = hex_char(data_q[11:8]);
            3'd3:    tx_byte_o = hex_char(data_q[7:4]);
            3'd4:    tx_byte_o = hex_char(data_q[3:0]);
            3'd5:    tx_byte_o = debug_pkg::char_cr;
            default: tx_byte_o = debug_pkg::char_lf;
        endcase
    end

    // host has to wait for the whole reply before the next read
    assert property (@(posedge clk) disable iff (!rst_n_i) rsp_i.valid |-> !busy);

endmodule

/* source/uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [7:0] tx_byte_i,
    input  logic       tx_valid_i,
    output logic       tx_ready_o,
    output logic       tx_o
);

    // stop, data, start, shifted out from bit 0
    logic [9:0]  frame_q;
    logic [3:0]  bits_left;
    logic [15:0] baud_cnt;

    assign tx_ready_o = (bits_left == 4'd0);
    assign tx_o       = frame_q[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            frame_q   <= '1;
            bits_left <= 4'd0;
            baud_cnt  <= 16'd0;
        end else if (bits_left == 4'd0) begin
            if (tx_valid_i) begin
                frame_q   <= {1'b1, tx_byte_i, 1'b0};
                bits_left <= 4'd10;
                baud_cnt  <= debug_pkg::clks_per_baud - 16'd1;
            end
        end else if (baud_cnt != 16'd0) begin
            baud_cnt <= baud_cnt - 16'd1;
        end else begin
            // line idles high once the stop bit is out
            frame_q   <= {1'b1, frame_q[9:1]};
            bits_left <= bits_left - 4'd1;
            baud_cnt  <= debug_pkg::clks_per_baud - 16'd1;
        end
    end

endmodule

/* source/debug_bridge_top.sv */
`timescale 1ns/1ps

module debug_bridge_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               rx_i,
    output logic               tx_o,
    input  debug_pkg::probe_t  probes_i,
    output logic               trig_o
);

    logic [7:0]          rx_byte;
    logic                rx_valid;
    debug_pkg::bus_req_t bus_req;
    debug_pkg::bus_rsp_t bus_rsp;
    logic [7:0]          tx_byte;
    logic                tx_valid;
    logic                tx_ready;

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    uart_receiver uart_receiver_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    request_parser request_parser_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .req_o      (bus_req)
    );

    trigger_block trigger_block_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (bus_req),
        .rsp_o    (bus_rsp),
        .probes_i (probes_i),
        .trig_o   (trig_o)
    );

    ////////////////////////////////////////////////////////////
    // reply path
    ////////////////////////////////////////////////////////////

    response_encoder response_encoder_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rsp_i      (bus_rsp),
        .tx_byte_o  (tx_byte),
        .tx_valid_o (tx_valid),
        .tx_ready_i (tx_ready)
    );

    uart_transmitter uart_transmitter_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_byte_i  (tx_byte),
        .tx_valid_i (tx_valid),
        .tx_ready_o (tx_ready),
        .tx_o       (tx_o)
    );

endmodule

/* tests/debug_bridge_tb.sv */
`timescale 1ns/1ps

module debug_bridge_tb;

    logic              clk;
    logic              rst_n_i;
    logic              rx_i;
    logic              tx_o;
    debug_pkg::probe_t probes_i;
    logic              trig_o;

    int pass_count;
    int fail_count;
    bit test_ok;

    debug_bridge_top debug_bridge_top_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rx_i     (rx_i),
        .tx_o     (tx_o),
        .probes_i (probes_i),
        .trig_o   (trig_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // ascii hex conversion
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] to_ascii_hex(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        // upper case letters from 0x41
        return 8'h37 + {4'h0, n};
    endfunction

    // bit 4 marks a legal digit
    function automatic logic [4:0] from_ascii_hex(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) begin
            return {1'b1, c[3:0]};
        end
        if (c >= 8'h41 && c <= 8'h46) begin
            return {1'b1, c[3:0] + 4'd9};
        end
        return 5'd0;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // serial driver and monitor
    ////////////////////////////////////////////////////////////

    // every step starts and returns on a falling edge
    task automatic send_char(input logic [7:0] c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_i = frame[i];
            repeat (debug_pkg::clks_per_baud) @(negedge clk);
        end
    endtask

    task automatic put_word(input logic [15:0] value);
        for (int i = 3; i >= 0; i--) begin
            send_char(to_ascii_hex(value[4*i +: 4]));
        end
    endtask

    task automatic recv_char(output logic [7:0] c, output bit framed, output bit seen);
        int waited;
        bit start_low;
        c      = 8'h00;
        framed = 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (tx_o !== 1'b0 && waited < 20 * debug_pkg::clks_per_baud) begin
            @(negedge clk);
            waited++;
        end
        if (tx_o === 1'b0) begin
            seen = 1'b1;
            // move to the middle of the start bit
            repeat (debug_pkg::clks_per_baud / 2) @(negedge clk);
            start_low = (tx_o === 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (debug_pkg::clks_per_baud) @(negedge clk);
                c[i] = tx_o;
            end
            repeat (debug_pkg::clks_per_baud) @(negedge clk);
            framed = start_low && (tx_o === 1'b1);
        end
    endtask

    // observation window, a reply would start within a few cycles
    task automatic expect_silence(input string name);
        bit seen;
        seen = 1'b0;
        repeat (3 * debug_pkg::clks_per_baud) begin
            @(negedge clk);
            if (tx_o !== 1'b1) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("%s: a reply came back where none was expected", name);
            test_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // trace steps
    ////////////////////////////////////////////////////////////

    task automatic write_step(input string name, input logic [15:0] addr,
                              input logic [15:0] data);
        send_char(debug_pkg::char_preamble);
        put_word(addr);
        put_word(data);
        send_char(debug_pkg::char_cr);
        expect_silence(name);
    endtask

    task automatic read_step(input string name, input logic [15:0] addr,
                             input logic [15:0] expected);
        logic [7:0]  reply [7];
        logic [7:0]  c;
        logic [4:0]  nib;
        logic [15:0] value;
        bit          framed;
        bit          seen;
        bit          shape_ok;
        int          got;
        send_char(debug_pkg::char_preamble);
        put_word(addr);
        send_char(debug_pkg::char_cr);
        got      = 0;
        shape_ok = 1'b1;
        value    = 16'h0000;
        seen     = 1'b1;
        while (seen && got < 7) begin
            recv_char(c, framed, seen);
            if (seen) begin
                reply[got] = c;
                shape_ok   = shape_ok && framed;
                got++;
            end
        end
        if (got < 7) begin
            $display("%s: reply stopped after %0d of 7 characters", name, got);
            test_ok = 1'b0;
        end else begin
            for (int i = 1; i <= 4; i++) begin
                nib      = from_ascii_hex(reply[i]);
                shape_ok = shape_ok && nib[4];
                value    = {value[11:0], nib[3:0]};
            end
            shape_ok = shape_ok && (reply[0] == debug_pkg::char_preamble)
                && (reply[5] == debug_pkg::char_cr) && (reply[6] == debug_pkg::char_lf);
            if (!shape_ok) begin
                $display("%s: reply is not framed as M, four hex digits, CR, LF", name);
                test_ok = 1'b0;
            end else begin
                compare_value(name, expected, value);
            end
        end
    endtask

    // 'G' in the middle of the address digits
    task automatic bad_line_step(input string name, input logic [15:0] addr);
        send_char(debug_pkg::char_preamble);
        send_char(to_ascii_hex(addr[15:12]));
        send_char(to_ascii_hex(addr[11:8]));
        send_char(8'h47);
        send_char(to_ascii_hex(addr[7:4]));
        send_char(to_ascii_hex(addr[3:0]));
        send_char(debug_pkg::char_cr);
        expect_silence(name);
    endtask

    // trig_o follows the probes one clock later
    task automatic probe_step(input string name, input debug_pkg::probe_t value,
                              input logic expected);
        probes_i = value;
        @(negedge clk);
        compare_value(name, {15'd0, expected}, {15'd0, trig_o});
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            pass_count++;
            $display("ok   %s", name);
        end else begin
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        string       kind;
        logic [15:0] f1;
        logic [15:0] f2;

        rst_n_i    = 1'b0;
        rx_i       = 1'b1;
        probes_i   = '0;
        pass_count = 0;
        fail_count = 0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        fd = $fopen("tests/debug_bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tests/debug_bridge_trace.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h", name, kind, f1, f2);
                    if (n == 4) begin
                        test_ok = 1'b1;
                        if (kind == "W") begin
                            write_step(name, f1, f2);
                        end else if (kind == "R") begin
                            read_step(name, f1, f2);
                        end else if (kind == "P") begin
                            probe_step(name, debug_pkg::probe_t'(f1[6:0]), f2[0]);
                        end else if (kind == "X") begin
                            bad_line_step(name, f1);
                        end else begin
                            $display("%s: unknown step kind %s in the trace", name, kind);
                            test_ok = 1'b0;
                        end
                        finish_test(name);
                    end else if (n > 0) begin
                        $display("trace line could not be read: %s", line);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* debug_bridge_top.f */
source/debug_pkg.sv
source/uart_receiver.sv
source/request_parser.sv
source/probe_trigger.sv
source/trigger_block.sv
source/response_encoder.sv
source/uart_transmitter.sv
source/debug_bridge_top.sv
tests/debug_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= debug_bridge_tb
FILELIST  ?= debug_bridge_top.f
TRACE     ?= tests/debug_bridge_trace.txt
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the testbench opens the trace from the project root
sim: $(FILELIST) $(TRACE)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/debug_bridge_trace.txt */
# name kind field1 field2
# W addr wdata, R addr expected rdata, P probes {a,b,c,d} expected trig_o, X addr 0000 (bad line)
wr_op_a      W 0000 1236
rd_op_a      R 0000 0006
wr_arg_a     W 0001 FFFF
rd_arg_a     R 0001 0001
wr_op_b      W 0002 0009
rd_op_b      R 0002 0009
wr_arg_b     W 0003 0002
rd_arg_b     R 0003 0000
wr_op_c      W 0004 ABC7
rd_op_c      R 0004 0007
wr_arg_c     W 0005 0003
rd_arg_c     R 0005 0001
wr_op_d      W 0006 0045
rd_op_d      R 0006 0005
wr_arg_d     W 0007 3C5A
rd_arg_d     R 0007 000A
rd_unmapped  R 0010 0000
rd_past_end  R 0008 0000
wr_dis_a     W 0000 0000
wr_dis_b     W 0002 0000
wr_dis_c     W 0004 0000
wr_eq_d      W 0006 0008
wr_arg5_d    W 0007 0005
p_d_eq       P 0005 0001
p_d_ne       P 0006 0000
wr_dis_d     W 0006 0000
wr_rise_a    W 0000 0001
p_a_low      P 0000 0000
p_a_hold     P 0000 0000
p_a_rise     P 0040 0001
p_a_high     P 0040 0000
bad_line     X 0003 0000
rd_after_bad R 0000 0001
wr_dis_a2    W 0000 0000
p_dis_all    P 007F 0000
p_dis_low    P 0000 0000
p_dis_mix    P 0055 0000
p_dis_alt    P 002A 0000
